/* compile.f */
+incdir+include
src/fdc_bus_pkg.sv
src/fdc_disk_pkg.sv
src/cru_control.sv
src/sector_buffer.sv
src/disk_service_port.sv
src/host_window.sv
src/fdc_card_top.sv
testbench/fdc_card_checker.sv
testbench/tb_fdc_card.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_fdc_card -o sim_fdc &&
./obj_dir/sim_fdc | tee /dev/stderr | grep -q "ALL CHECKS PASSED" &&
echo "simulation run passed" ||
{ echo "simulation run failed"; exit 1; }

/* testbench/tb_fdc_card.sv */
`timescale 1ns/1ps
`include "fdc_settings.svh"

module tb_fdc_card;
   import fdc_bus_pkg::*;
   import fdc_disk_pkg::*;

   localparam int SEL_CRU     = 0;
   localparam int SEL_LED     = 1;
   localparam int SEL_READY   = 2;
   localparam int SEL_Q       = 3;
   localparam int SEL_SVC     = 4;
   localparam int SEL_CRU_SEL = 5;
   localparam int SEL_Q_SEL   = 6;
   localparam int SEL_TICKS   = 7;

   logic        clk;
   logic        reset;
   logic        clk_3mhz_en = 1'b0;
   logic [1:0]  tick_cnt = 2'd0;
   cpu_addr_t   addr;
   cpu_data_t   data;
   logic        memen;
   logic        we;
   logic        cruclk;
   cpu_data_t   q;
   logic        q_select;
   logic        cruin;
   logic        cru_select;
   logic        ready;
   logic        led;
   logic        svc_req;
   logic        svc_we;
   logic [8:0]  svc_adr;
   logic [7:0]  svc_wdat;
   logic [7:0]  svc_rdat;
   logic        svc_ack;
   logic        chk_en;
   logic [2:0]  chk_sel;
   logic [15:0] chk_exp;
   logic [3:0]  chk_tol;
   logic [15:0] obs;
   logic        test_done;
   logic [3:0]  test_num;
   int          total_checks;
   int          total_errors;
   logic [7:0]  cru_m;                       // model of the written CRU bits
   logic        drives_on_m;
   logic [7:0]  buf_m [0:`FDC_BUF_BYTES-1];
   buf_addr_t   pos_m;
   int          n;
   logic [7:0]  want_q;

   fdc_card_top DUT (
      .clk (clk), .reset (reset), .clk_3mhz_en_i (clk_3mhz_en),
      .addr_i (addr), .data_i (data), .memen_i (memen), .we_i (we), .cruclk_i (cruclk),
      .q_o (q), .q_select_o (q_select), .cruin_o (cruin), .cru_select_o (cru_select),
      .ready_o (ready), .led_o (led),
      .svc_req_i (svc_req), .svc_we_i (svc_we), .svc_adr_i (svc_adr), .svc_dat_i (svc_wdat),
      .svc_dat_o (svc_rdat), .svc_ack_o (svc_ack)
   );

   fdc_card_checker u_checker (
      .clk (clk), .chk_en_i (chk_en), .chk_sel_i (chk_sel), .chk_exp_i (chk_exp),
      .chk_tol_i (chk_tol), .obs_i (obs), .test_done_i (test_done), .test_num_i (test_num),
      .cruin_i (cruin), .led_i (led), .ready_i (ready), .q_i (q), .svc_dat_i (svc_rdat),
      .cru_select_i (cru_select), .q_select_i (q_select),
      .checks_o (total_checks), .errors_o (total_errors)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // 3 MHz tick every third clock
   always @(posedge clk) begin
      tick_cnt    <= (tick_cnt == 2'd2) ? 2'd0 : tick_cnt + 2'd1;
      clk_3mhz_en <= (tick_cnt == 2'd2);
   end

   function automatic cpu_addr_t cru_addr(input int b, input logic val);
      return {8'h11, 4'h0, 3'(b), val};
   endfunction

   function automatic cpu_addr_t win_addr(input int idx);
      return {12'h5ff, 3'(idx), 1'b0};
   endfunction

   function automatic logic cru_expect(input int b);
      case (b)
         0: return 1'b0;   // nothing pending in test 1
         1, 2, 3: return cru_m[b + 3] && drives_on_m;
         4: return !drives_on_m;
         5: return 1'b0;
         6: return 1'b1;
         default: return cru_m[7];
      endcase
   endfunction

   function automatic logic [7:0] status_byte(input logic on, input logic wp,
                                              input logic nm, input logic pend);
      return {!on, wp, nm, 4'b0000, pend};
   endfunction

   function automatic logic [7:0] bus_inv(input logic [7:0] b);
      return ~b;
   endfunction

   task automatic give_up(input string what);
      $display("timeout while waiting for %s", what);
      $display("CHECKS FAILED");
      $finish;
   endtask

   task automatic start_check(input int sel, input int want, input int tol);
      chk_en  <= 1'b1;
      chk_sel <= 3'(sel);
      chk_exp <= 16'(want);
      chk_tol <= 4'(tol);
   endtask

   task automatic check_port(input int sel, input int want, input int tol);
      start_check(sel, want, tol);
      @(posedge clk);
      chk_en <= 1'b0;
   endtask

   task automatic end_test(input int num);
      @(posedge clk);
      test_done <= 1'b1;
      test_num  <= 4'(num);
      @(posedge clk);
      test_done <= 1'b0;
   endtask

   task automatic cru_write(input int b, input logic val);
      @(posedge clk);
      addr   <= cru_addr(b, val);
      cruclk <= 1'b1;
      @(posedge clk);
      cruclk <= 1'b0;
      if (b == 1 && val && !cru_m[1]) drives_on_m = 1'b1;
      cru_m[b] = val;
   endtask

   task automatic cru_check(input int b);
      @(posedge clk);
      addr <= cru_addr(b, 1'b0);
      check_port(SEL_CRU, int'(cru_expect(b)), 0);
      check_port(SEL_CRU_SEL, 1, 0);   // every address here has the CRU base
   endtask

   task automatic wait_drives_off();
      int cnt;
      cnt = 0;
      @(posedge clk);
      addr <= cru_addr(4, 1'b0);
      @(posedge clk);
      while (!cruin) begin
         cnt++;
         if (cnt > `FDC_WAIT_LIMIT) give_up("drives to turn off");
         @(posedge clk);
      end
      drives_on_m = 1'b0;
   endtask

   // counts ticks while drives are on and stops at cap or when they drop
   task automatic count_ticks(input int cap, output int ticks);
      int cnt;
      ticks = 0;
      cnt = 0;
      @(posedge clk);
      addr <= cru_addr(4, 1'b0);
      @(posedge clk);
      while (cruin) begin
         cnt++;
         if (cnt > `FDC_WAIT_LIMIT) give_up("drives to turn on");
         @(posedge clk);
      end
      while (!cruin && ticks < cap) begin
         if (clk_3mhz_en) ticks++;
         cnt++;
         if (cnt > `FDC_WAIT_LIMIT) give_up("motor timeout");
         @(posedge clk);
      end
   endtask

   task automatic cpu_access(input int idx, input logic wr, input logic [7:0] val,
                             input logic [7:0] want, input logic chk);
      int cnt;
      @(posedge clk);
      addr  <= win_addr(idx);
      data  <= bus_inv(val);
      we    <= wr;
      memen <= 1'b1;
      start_check(SEL_Q_SEL, int'(cru_m[0]), 0);   // window decode needs page enable
      cnt = 0;
      @(posedge clk);
      chk_en <= 1'b0;
      while (!ready) begin
         cnt++;
         if (cnt > `FDC_WAIT_LIMIT) give_up("ready_o");
         @(posedge clk);
      end
      if (chk) start_check(SEL_Q, int'(want), 0);
      @(posedge clk);
      if (chk) chk_en <= 1'b0;
      memen <= 1'b0;
      we    <= 1'b0;
      if (idx == 3 && wr) pos_m = '0;
      if (idx == 2) begin
         if (wr) buf_m[pos_m] = val;
         pos_m = pos_m + 8'd1;
      end
   endtask

   task automatic svc_access(input logic [8:0] adr, input logic wr, input logic [7:0] val,
                             input logic [7:0] want, input logic chk);
      int cnt;
      @(posedge clk);
      svc_req  <= 1'b1;
      svc_we   <= wr;
      svc_adr  <= adr;
      svc_wdat <= val;
      cnt = 0;
      @(posedge clk);
      while (!svc_ack) begin
         cnt++;
         if (cnt > `FDC_WAIT_LIMIT) give_up("svc_ack_o to rise");
         @(posedge clk);
      end
      svc_req <= 1'b0;
      if (chk) start_check(SEL_SVC, int'(want), 0);
      @(posedge clk);
      if (chk) chk_en <= 1'b0;
      while (svc_ack) begin
         cnt++;
         if (cnt > `FDC_WAIT_LIMIT) give_up("svc_ack_o to fall");
         @(posedge clk);
      end
   endtask

   initial begin
      reset = 1'b1;
      addr = '0;
      data = '0;
      memen = 1'b0;
      we = 1'b0;
      cruclk = 1'b0;
      svc_req = 1'b0;
      svc_we = 1'b0;
      svc_adr = '0;
      svc_wdat = '0;
      chk_en = 1'b0;
      chk_sel = '0;
      chk_exp = '0;
      chk_tol = '0;
      obs = '0;
      test_done = 1'b0;
      test_num = '0;
      cru_m = '0;
      drives_on_m = 1'b0;
      pos_m = '0;
      void'($urandom(32'h6a3e_b467));
      repeat (3) @(posedge clk);
      reset <= 1'b0;

      for (int i = 0; i < 24; i++) begin
         cru_write($urandom % 8, 1'($urandom % 2));
         cru_check($urandom % 8);
         @(posedge clk);
         check_port(SEL_LED, int'(cru_m[0]), 0);
      end
      end_test(1);

      wait_drives_off();
      cru_write(1, 1'b0);
      cru_write(1, 1'b1);
      count_ticks(100000, n);
      obs <= 16'(n);
      check_port(SEL_TICKS, `FDC_MOTOR_TICKS, 1);
      cru_write(1, 1'b0);
      cru_write(1, 1'b1);
      count_ticks(100, n);
      cru_write(1, 1'b0);
      cru_write(1, 1'b1);   // restart halfway
      count_ticks(100000, n);
      obs <= 16'(n);
      check_port(SEL_TICKS, `FDC_MOTOR_TICKS, 1);
      end_test(2);

      for (int a = 0; a < `FDC_BUF_BYTES; a++) begin
         buf_m[a] = 8'($urandom);
         svc_access({1'b0, 8'(a)}, 1'b1, buf_m[a], 8'h00, 1'b0);
      end
      svc_access(9'h100, 1'b1, 8'h10, 8'h00, 1'b0);   // mount drive 1
      svc_access(9'h100, 1'b0, 8'h00, 8'h10, 1'b1);
      cru_write(0, 1'b1);
      cpu_access(3, 1'b1, 8'h00, 8'h00, 1'b0);
      for (int i = 0; i < `FDC_BUF_BYTES; i++) begin
         cpu_access(2, 1'b0, 8'h00, bus_inv(buf_m[pos_m]), 1'b1);
      end
      end_test(3);

      cru_write(2, 1'b1);
      cru_write(4, 1'b1);
      cru_write(5, 1'b0);
      cru_write(6, 1'b0);
      cru_write(1, 1'b0);
      cru_write(1, 1'b1);
      cpu_access(3, 1'b1, 8'h01, 8'h00, 1'b0);   // read sector
      cpu_access(0, 1'b0, 8'h00, bus_inv(status_byte(1'b1, 1'b0, 1'b0, 1'b1)), 1'b1);
      svc_access(9'h101, 1'b0, 8'h00, 8'h10, 1'b1);
      want_q = bus_inv(buf_m[pos_m]);
      fork
         cpu_access(2, 1'b0, 8'h00, want_q, 1'b1);
         begin
            repeat (4) @(posedge clk);
            check_port(SEL_READY, 0, 0);
            svc_access(9'h102, 1'b1, 8'h01, 8'h00, 1'b0);
         end
      join
      svc_access(9'h101, 1'b0, 8'h00, 8'h00, 1'b1);
      svc_access(9'h102, 1'b1, 8'h00, 8'h00, 1'b0);
      end_test(4);

      cru_write(1, 1'b0);
      cru_write(1, 1'b1);
      svc_access(9'h100, 1'b1, 8'h11, 8'h00, 1'b0);   // drive 1 write protected
      cpu_access(3, 1'b1, 8'h02, 8'h00, 1'b0);
      cpu_access(0, 1'b0, 8'h00, bus_inv(status_byte(1'b1, 1'b1, 1'b0, 1'b0)), 1'b1);
      svc_access(9'h101, 1'b0, 8'h00, 8'h00, 1'b1);
      wait_drives_off();
      cpu_access(3, 1'b1, 8'h01, 8'h00, 1'b0);
      cpu_access(0, 1'b0, 8'h00, bus_inv(status_byte(1'b0, 1'b0, 1'b1, 1'b0)), 1'b1);
      svc_access(9'h101, 1'b0, 8'h00, 8'h00, 1'b1);
      end_test(5);

      cpu_access(3, 1'b1, 8'h00, 8'h00, 1'b0);
      fork
         for (int i = 0; i < `FDC_BUF_BYTES; i++) begin
            cpu_access(2, 1'b1, 8'($urandom), 8'h00, 1'b0);
         end
         for (int j = 0; j < 64; j++) begin
            svc_access({1'b0, 8'($urandom)}, 1'b0, 8'h00, 8'h00, 1'b0);
         end
      join
      for (int a = 0; a < `FDC_BUF_BYTES; a++) begin
         svc_access({1'b0, 8'(a)}, 1'b0, 8'h00, buf_m[a], 1'b1);
      end
      end_test(6);

      @(posedge clk);
      $display("total: %0d checks, %0d errors", total_checks, total_errors);
      if (total_errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

/* testbench/fdc_card_checker.sv */
`timescale 1ns/1ps

module fdc_card_checker (
   input  logic        clk,
   input  logic        chk_en_i,
   input  logic [2:0]  chk_sel_i,
   input  logic [15:0] chk_exp_i,
   input  logic [3:0]  chk_tol_i,
   input  logic [15:0] obs_i,
   input  logic        test_done_i,
   input  logic [3:0]  test_num_i,
   input  logic        cruin_i,
   input  logic        led_i,
   input  logic        ready_i,
   input  logic [7:0]  q_i,
   input  logic [7:0]  svc_dat_i,
   input  logic        cru_select_i,
   input  logic        q_select_i,
   output int          checks_o,
   output int          errors_o
);

   int    act;
   int    total_checks = 0;
   int    total_errors = 0;
   int    test_checks = 0;
   int    test_errors = 0;
   string name;

   assign checks_o = total_checks;
   assign errors_o = total_errors;

   // inputs were driven on the previous edge, so they are settled here
   always @(posedge clk) begin
      if (chk_en_i) begin
         case (chk_sel_i)
            3'd0: begin name = "cruin_o";   act = int'(cruin_i);   end
            3'd1: begin name = "led_o";     act = int'(led_i);     end
            3'd2: begin name = "ready_o";   act = int'(ready_i);   end
            3'd3: begin name = "q_o";       act = int'(q_i);       end
            3'd4: begin name = "svc_dat_o"; act = int'(svc_dat_i); end
            3'd5: begin name = "cru_select_o"; act = int'(cru_select_i); end
            3'd6: begin name = "q_select_o";   act = int'(q_select_i);   end
            default: begin name = "drives_on ticks"; act = int'(obs_i); end
         endcase
         total_checks++;
         test_checks++;
         // port values use a zero tolerance
         if (act > int'(chk_exp_i) + int'(chk_tol_i) ||
             act + int'(chk_tol_i) < int'(chk_exp_i)) begin
            total_errors++;
            test_errors++;
            $display("CHECK FAILED %s expected %h got %h", name, chk_exp_i, act[15:0]);
         end
      end
      if (test_done_i) begin
         $display("test %0d: %0d checks, %0d errors", test_num_i, test_checks, test_errors);
         test_checks = 0;
         test_errors = 0;
      end
   end

endmodule

/* src/fdc_card_top.sv */
`timescale 1ns/1ps

module fdc_card_top (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   clk_3mhz_en_i,
   input  fdc_bus_pkg::cpu_addr_t addr_i,
   input  fdc_bus_pkg::cpu_data_t data_i,
   input  logic                   memen_i,
   input  logic                   we_i,
   input  logic                   cruclk_i,
   output fdc_bus_pkg::cpu_data_t q_o,
   output logic                   q_select_o,
   output logic                   cruin_o,
   output logic                   cru_select_o,
   output logic                   ready_o,
   output logic                   led_o,
   input  logic                   svc_req_i,
   input  logic                   svc_we_i,
   input  logic [8:0]             svc_adr_i,
   input  logic [7:0]             svc_dat_i,
   output logic [7:0]             svc_dat_o,
   output logic                   svc_ack_o
);
   import fdc_disk_pkg::*;

   drive_mask_t drive_sel;
   drive_mask_t mounted;
   drive_mask_t wprot;
   drive_mask_t xfer_rd_set;
   drive_mask_t xfer_wr_set;
   logic        drives_on;
   logic        page_en;
   logic        wait_en;
   logic        xfer_pending;
   logic [7:0]  sector;
   buf_addr_t   host_buf_addr;
   logic        host_buf_we;
   logic [7:0]  host_buf_wdata;
   logic        host_buf_active;
   logic [7:0]  host_buf_rdata;
   logic        svc_buf_req;
   logic        svc_buf_we;
   buf_addr_t   svc_buf_addr;
   logic [7:0]  svc_buf_wdata;
   logic        svc_buf_grant;
   logic [7:0]  svc_buf_rdata;

   cru_control u_cru (
      .clk            (clk),
      .reset          (reset),
      .clk_3mhz_en_i  (clk_3mhz_en_i),
      .addr_i         (addr_i),
      .cruclk_i       (cruclk_i),
      .xfer_pending_i (xfer_pending),
      .cruin_o        (cruin_o),
      .cru_select_o   (cru_select_o),
      .page_en_o      (page_en),
      .wait_en_o      (wait_en),
      .drives_on_o    (drives_on),
      .drive_sel_o    (drive_sel),
      .side_o         ()   // read back over CRU only
   );

   disk_service_port u_svc (
      .clk             (clk),
      .reset           (reset),
      .svc_req_i       (svc_req_i),
      .svc_we_i        (svc_we_i),
      .svc_adr_i       (svc_adr_i),
      .svc_dat_i       (svc_dat_i),
      .xfer_rd_set_i   (xfer_rd_set),
      .xfer_wr_set_i   (xfer_wr_set),
      .sector_i        (sector),
      .svc_buf_grant_i (svc_buf_grant),
      .svc_buf_rdata_i (svc_buf_rdata),
      .svc_dat_o       (svc_dat_o),
      .svc_ack_o       (svc_ack_o),
      .mounted_o       (mounted),
      .wprot_o         (wprot),
      .xfer_pending_o  (xfer_pending),
      .svc_buf_req_o   (svc_buf_req),
      .svc_buf_we_o    (svc_buf_we),
      .svc_buf_addr_o  (svc_buf_addr),
      .svc_buf_wdata_o (svc_buf_wdata)
   );

   sector_buffer u_buf (
      .clk           (clk),
      .host_addr_i   (host_buf_addr),
      .host_we_i     (host_buf_we),
      .host_wdata_i  (host_buf_wdata),
      .host_active_i (host_buf_active),
      .svc_req_i     (svc_buf_req),
      .svc_we_i      (svc_buf_we),
      .svc_addr_i    (svc_buf_addr),
      .svc_wdata_i   (svc_buf_wdata),
      .host_rdata_o  (host_buf_rdata),
      .svc_grant_o   (svc_buf_grant),
      .svc_rdata_o   (svc_buf_rdata)
   );

   host_window u_win (
      .clk               (clk),
      .reset             (reset),
      .addr_i            (addr_i),
      .data_i            (data_i),
      .memen_i           (memen_i),
      .we_i              (we_i),
      .page_en_i         (page_en),
      .wait_en_i         (wait_en),
      .drives_on_i       (drives_on),
      .drive_sel_i       (drive_sel),
      .mounted_i         (mounted),
      .wprot_i           (wprot),
      .xfer_pending_i    (xfer_pending),
      .host_rdata_i      (host_buf_rdata),
      .q_o               (q_o),
      .q_select_o        (q_select_o),
      .ready_o           (ready_o),
      .led_o             (led_o),
      .xfer_rd_set_o     (xfer_rd_set),
      .xfer_wr_set_o     (xfer_wr_set),
      .sector_o          (sector),
      .host_buf_addr_o   (host_buf_addr),
      .host_buf_we_o     (host_buf_we),
      .host_buf_wdata_o  (host_buf_wdata),
      .host_buf_active_o (host_buf_active)
   );

endmodule

/* src/host_window.sv */
`timescale 1ns/1ps
`include "fdc_settings.svh"

module host_window (
   input  logic                      clk,
   input  logic                      reset,
   input  fdc_bus_pkg::cpu_addr_t    addr_i,
   input  fdc_bus_pkg::cpu_data_t    data_i,
   input  logic                      memen_i,
   input  logic                      we_i,
   input  logic                      page_en_i,
   input  logic                      wait_en_i,
   input  logic                      drives_on_i,
   input  fdc_disk_pkg::drive_mask_t drive_sel_i,
   input  fdc_disk_pkg::drive_mask_t mounted_i,
   input  fdc_disk_pkg::drive_mask_t wprot_i,
   input  logic                      xfer_pending_i,
   input  logic [7:0]                host_rdata_i,
   output fdc_bus_pkg::cpu_data_t    q_o,
   output logic                      q_select_o,
   output logic                      ready_o,
   output logic                      led_o,
   output fdc_disk_pkg::drive_mask_t xfer_rd_set_o,
   output fdc_disk_pkg::drive_mask_t xfer_wr_set_o,
   output logic [7:0]                sector_o,
   output fdc_disk_pkg::buf_addr_t   host_buf_addr_o,
   output logic                      host_buf_we_o,
   output logic [7:0]                host_buf_wdata_o,
   output logic                      host_buf_active_o
);
   import fdc_bus_pkg::*;
   import fdc_disk_pkg::*;

   win_reg_t   reg_idx;
   cpu_data_t  wdata;
   cpu_data_t  reg_val;
   logic [7:0] status_b;
   logic       acc;
   logic       data_acc;
   logic       wr_stb;
   logic       no_drive;
   logic       sel_wp;
   logic       memen_q;
   logic       data_acc_q;
   logic [7:0] cmd_q;
   logic       err_wp_q;
   logic       err_nm_q;
   buf_addr_t  data_pos_q;

   assign q_select_o = page_en_i && (addr_i[0:11] == `FDC_WINDOW_HI);
   assign led_o      = page_en_i;
   assign reg_idx    = addr_i[12:14];
   assign acc        = q_select_o && memen_i;
   assign data_acc   = acc && (reg_idx == 3'd2);
   assign wr_stb     = acc && we_i && !memen_q;   // first cycle only
   assign wdata      = ~data_i;                   // card inverts the bus

   assign no_drive = !drives_on_i || ((drive_sel_i & mounted_i) == '0);
   assign sel_wp   = (drive_sel_i & wprot_i) != '0;

   assign host_buf_addr_o   = data_pos_q;
   assign host_buf_we_o     = wr_stb && (reg_idx == 3'd2);
   assign host_buf_wdata_o  = wdata;
   assign host_buf_active_o = data_acc;

   // stall data accesses until the service side acks
   assign ready_o  = !(data_acc && wait_en_i && xfer_pending_i && drives_on_i);
   assign status_b = {!drives_on_i, err_wp_q, err_nm_q, 4'b0000, xfer_pending_i};

   always_comb begin
      case (reg_idx)
         3'd0: reg_val = status_b;
         3'd1: reg_val = sector_o;
         3'd2: reg_val = host_rdata_i;   // valid from second cycle
         3'd3: reg_val = cmd_q;
         default: reg_val = '0;
      endcase
   end

   assign q_o = ~reg_val;

   always_ff @(posedge clk) begin
      if (reset) begin
         memen_q       <= 1'b0;
         data_acc_q    <= 1'b0;
         sector_o      <= '0;
         cmd_q         <= '0;
         err_wp_q      <= 1'b0;
         err_nm_q      <= 1'b0;
         data_pos_q    <= '0;
         xfer_rd_set_o <= '0;
         xfer_wr_set_o <= '0;
      end else begin
         memen_q       <= memen_i;
         data_acc_q    <= data_acc;
         xfer_rd_set_o <= '0;
         xfer_wr_set_o <= '0;
         if (data_acc_q && !memen_i) begin
            data_pos_q <= data_pos_q + 1'b1;   // wraps at 256
         end
         if (wr_stb) begin
            case (reg_idx)
               3'd1: sector_o <= wdata;
               3'd3: begin
                  cmd_q      <= wdata;
                  data_pos_q <= '0;
                  if (wdata == 8'd1 || wdata == 8'd2) begin
                     err_nm_q <= no_drive;
                     err_wp_q <= (wdata == 8'd2) && !no_drive && sel_wp;
                     if (!no_drive && wdata == 8'd1) begin
                        xfer_rd_set_o <= drive_sel_i;
                     end
                     if (!no_drive && !sel_wp && wdata == 8'd2) begin
                        xfer_wr_set_o <= drive_sel_i;
                     end
                  end
               end
               default: ;
            endcase
         end
      end
   end

endmodule

/* src/disk_service_port.sv */
`timescale 1ns/1ps

module disk_service_port (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      svc_req_i,
   input  logic                      svc_we_i,
   input  logic [8:0]                svc_adr_i,
   input  logic [7:0]                svc_dat_i,
   input  fdc_disk_pkg::drive_mask_t xfer_rd_set_i,
   input  fdc_disk_pkg::drive_mask_t xfer_wr_set_i,
   input  logic [7:0]                sector_i,
   input  logic                      svc_buf_grant_i,
   input  logic [7:0]                svc_buf_rdata_i,
   output logic [7:0]                svc_dat_o,
   output logic                      svc_ack_o,
   output fdc_disk_pkg::drive_mask_t mounted_o,
   output fdc_disk_pkg::drive_mask_t wprot_o,
   output logic                      xfer_pending_o,
   output logic                      svc_buf_req_o,
   output logic                      svc_buf_we_o,
   output fdc_disk_pkg::buf_addr_t   svc_buf_addr_o,
   output logic [7:0]                svc_buf_wdata_o
);
   import fdc_disk_pkg::*;

   svc_reg_t    reg_idx;
   logic        start;
   logic        step;
   logic        reg_wr;
   logic        ack_rise;
   logic        busy_q;
   logic        ack_bit_q;
   drive_mask_t rd_mask_q;
   drive_mask_t wr_mask_q;
   logic [7:0]  reg_rdata;
   logic [7:0]  dat_q;
   xfer_state_e state_q;

   assign reg_idx  = svc_adr_i[1:0];
   assign start    = svc_req_i && !busy_q && !svc_ack_o;
   assign step     = start && (svc_adr_i[8] || svc_buf_grant_i);   // buffer waits for grant
   assign reg_wr   = step && svc_adr_i[8] && svc_we_i;
   assign ack_rise = reg_wr && (reg_idx == 2'd2) && svc_dat_i[0] && !ack_bit_q;

   assign svc_buf_req_o   = start && !svc_adr_i[8];
   assign svc_buf_we_o    = svc_we_i;
   assign svc_buf_addr_o  = svc_adr_i[7:0];
   assign svc_buf_wdata_o = svc_dat_i;
   assign svc_dat_o       = dat_q;
   assign xfer_pending_o  = (state_q == REQ_READ) || (state_q == REQ_WRITE);

   // four-phase handshake, ack two cycles after the access starts
   always_ff @(posedge clk) begin
      if (reset) begin
         busy_q    <= 1'b0;
         svc_ack_o <= 1'b0;
      end else begin
         busy_q <= step;
         if (busy_q) begin
            svc_ack_o <= 1'b1;
         end else if (!svc_req_i) begin
            svc_ack_o <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (busy_q) begin
         dat_q <= svc_adr_i[8] ? reg_rdata : svc_buf_rdata_i;
      end
   end

   always_comb begin
      case (reg_idx)
         2'd0: reg_rdata = {1'b0, mounted_o, 1'b0, wprot_o};
         2'd1: reg_rdata = {1'b0, rd_mask_q, 1'b0, wr_mask_q};
         2'd2: reg_rdata = {7'd0, ack_bit_q};
         default: reg_rdata = sector_i;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         mounted_o <= '0;
         wprot_o   <= '0;
         ack_bit_q <= 1'b0;
      end else if (reg_wr) begin
         if (reg_idx == 2'd0) begin
            mounted_o <= svc_dat_i[6:4];
            wprot_o   <= svc_dat_i[2:0];
         end
         if (reg_idx == 2'd2) begin
            ack_bit_q <= svc_dat_i[0];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state_q   <= IDLE;
         rd_mask_q <= '0;
         wr_mask_q <= '0;
      end else begin
         case (state_q)
            IDLE: begin
               if (xfer_rd_set_i != '0) begin
                  rd_mask_q <= xfer_rd_set_i;
                  state_q   <= REQ_READ;
               end else if (xfer_wr_set_i != '0) begin
                  wr_mask_q <= xfer_wr_set_i;
                  state_q   <= REQ_WRITE;
               end
            end
            REQ_READ, REQ_WRITE: begin
               if (ack_rise) begin
                  rd_mask_q <= '0;
                  wr_mask_q <= '0;
                  state_q   <= ACKED;
               end
            end
            default: begin
               if (!ack_bit_q) begin   // wait for ack written back to zero
                  state_q <= IDLE;
               end
            end
         endcase
      end
   end

endmodule

/* src/sector_buffer.sv */
`timescale 1ns/1ps
`include "fdc_settings.svh"

module sector_buffer (
   input  logic                    clk,
   input  fdc_disk_pkg::buf_addr_t host_addr_i,
   input  logic                    host_we_i,
   input  logic [7:0]              host_wdata_i,
   input  logic                    host_active_i,
   input  logic                    svc_req_i,
   input  logic                    svc_we_i,
   input  fdc_disk_pkg::buf_addr_t svc_addr_i,
   input  logic [7:0]              svc_wdata_i,
   output logic [7:0]              host_rdata_o,
   output logic                    svc_grant_o,
   output logic [7:0]              svc_rdata_o
);
   import fdc_disk_pkg::*;

   logic [7:0] mem_q [0:`FDC_BUF_BYTES-1];
   logic [7:0] rd_q;
   buf_addr_t  port_addr;

   // host owns the port for a whole data access
   assign svc_grant_o = svc_req_i && !host_active_i;
   assign port_addr   = svc_grant_o ? svc_addr_i : host_addr_i;

   always_ff @(posedge clk) begin
      if (svc_grant_o && svc_we_i) begin
         mem_q[port_addr] <= svc_wdata_i;
      end else if (host_we_i) begin
         mem_q[port_addr] <= host_wdata_i;
      end
      rd_q <= mem_q[port_addr];   // read-before-write
   end

   // one read register, whoever held the port last cycle
   assign host_rdata_o = rd_q;
   assign svc_rdata_o  = rd_q;

endmodule

/* src/cru_control.sv */
`timescale 1ns/1ps
`include "fdc_settings.svh"

module cru_control (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      clk_3mhz_en_i,
   input  fdc_bus_pkg::cpu_addr_t    addr_i,
   input  logic                      cruclk_i,
   input  logic                      xfer_pending_i,
   output logic                      cruin_o,
   output logic                      cru_select_o,
   output logic                      page_en_o,
   output logic                      wait_en_o,
   output logic                      drives_on_o,
   output fdc_disk_pkg::drive_mask_t drive_sel_o,
   output logic                      side_o
);
   import fdc_bus_pkg::*;

   localparam int CNT_W = $clog2(`FDC_MOTOR_TICKS);

   cru_bit_t         bit_idx;
   logic [7:0]       cru_q;         // page, kick, wait, hld, ds1, ds2, ds3, side
   logic             kick_prev_q;
   logic [CNT_W-1:0] ena_count_q;

   assign bit_idx      = addr_i[12:14];
   assign cru_select_o = (addr_i[0:7] == `FDC_CRU_BASE);

   assign page_en_o   = cru_q[0];
   assign wait_en_o   = cru_q[2];
   assign side_o      = cru_q[7];
   assign drive_sel_o = cru_q[6:4] & {3{drives_on_o}};   // selects only count while enabled

   always_ff @(posedge clk) begin
      if (reset) begin
         cru_q <= '0;
      end else if (cruclk_i && cru_select_o) begin
         cru_q[bit_idx] <= addr_i[15];   // bit 15 carries the value
      end
   end

   // motor one-shot, retriggered by every rising kick
   always_ff @(posedge clk) begin
      if (reset) begin
         kick_prev_q <= 1'b0;
         drives_on_o <= 1'b0;
         ena_count_q <= '0;
      end else begin
         kick_prev_q <= cru_q[1];
         if (cru_q[1] && !kick_prev_q) begin
            drives_on_o <= 1'b1;
            ena_count_q <= CNT_W'(`FDC_MOTOR_TICKS - 1);
         end else if (drives_on_o && clk_3mhz_en_i) begin
            if (ena_count_q != '0) begin
               ena_count_q <= ena_count_q - 1'b1;
            end else begin
               drives_on_o <= 1'b0;
            end
         end
      end
   end

   always_comb begin
      case (bit_idx)
         3'd0: cruin_o = xfer_pending_i;
         3'd1: cruin_o = drive_sel_o[0];
         3'd2: cruin_o = drive_sel_o[1];
         3'd3: cruin_o = drive_sel_o[2];
         3'd4: cruin_o = !drives_on_o;
         3'd5: cruin_o = 1'b0;
         3'd6: cruin_o = 1'b1;
         default: cruin_o = side_o;
      endcase
   end

endmodule

/* src/fdc_disk_pkg.sv */
package fdc_disk_pkg;

   typedef logic [7:0] buf_addr_t;
   typedef logic [2:0] drive_mask_t;   // bit 0 is drive 1
   typedef logic [1:0] svc_reg_t;

   typedef enum logic [1:0] {
      IDLE,
      REQ_READ,
      REQ_WRITE,
      ACKED
   } xfer_state_e;

endpackage

/* src/fdc_bus_pkg.sv */
package fdc_bus_pkg;

   // cpu numbering, bit 0 is the msb
   typedef logic [0:15] cpu_addr_t;
   typedef logic [0:7]  cpu_data_t;

   typedef logic [2:0] cru_bit_t;   // from addr bits 12 to 14
   typedef logic [2:0] win_reg_t;   // window register

endpackage

/* include/fdc_settings.svh */
`ifndef FDC_SETTINGS_SVH
`define FDC_SETTINGS_SVH

// drive enable hold time in 3 MHz ticks, kept short for simulation
`define FDC_MOTOR_TICKS 200

// high 12 address bits of the host window
`define FDC_WINDOW_HI 12'h5ff

// high 8 bits of the CRU address
`define FDC_CRU_BASE 8'h11

`define FDC_BUF_BYTES 256

// cycles before a testbench wait gives up
`define FDC_WAIT_LIMIT 200000

`endif
